//--- read_geometry_pkg.sv
`default_nettype none

package read_geometry_pkg;

	// batch and read numbering
	localparam int batch_width = 5;
	localparam int read_num_width = 4;
	localparam logic [batch_width-1:0] max_reads = 16;

	// host side load beat
	localparam int beat_width = 512;

	// bases as stored with a 2-bit code per base
	localparam int bases_per_word = 64;
	localparam int base_width = 2;
	localparam int packed_word_width = bases_per_word * base_width;

	// query side
	localparam int position_width = 7;
	localparam int result_width = 8;

endpackage

`default_nettype wire

//--- read_format_pkg.sv
`default_nettype none

package read_format_pkg;

	localparam int field_width = 7;

	// order of beats within one read
	localparam logic [1:0] phase_base_lo = 2'd0;
	localparam logic [1:0] phase_base_hi = 2'd1;
	localparam logic [1:0] phase_param = 2'd2;

	// forward start at bits 6..0 and min interval at bits 70..64
	typedef struct packed {
		logic [read_geometry_pkg::beat_width-72:0] reserved_hi;
		logic [field_width-1:0] min_intv;
		logic [63-field_width:0] reserved_lo;
		logic [field_width-1:0] forward_i;
	} param_t;

	// one lane per base with the base code in its two low bits
	typedef union packed {
		logic [read_geometry_pkg::bases_per_word-1:0][read_geometry_pkg::result_width-1:0] lanes;
		param_t param;
	} beat_t;

endpackage

`default_nettype wire

//--- read_loader.sv
`default_nettype none
`timescale 1ns/1ns

module read_loader (
	input wire clk,
	input wire reset_n,
	input wire load_valid,
	input wire read_format_pkg::beat_t load_data,
	input wire [read_geometry_pkg::batch_width-1:0] batch_size,
	output logic load_done,
	output logic [read_geometry_pkg::batch_width-1:0] read_count,
	output logic wr_en,
	output logic [1:0] wr_sel,
	output logic [read_geometry_pkg::read_num_width-1:0] wr_read_num,
	output logic [read_geometry_pkg::packed_word_width-1:0] wr_bases,
	output logic [read_format_pkg::field_width-1:0] wr_forward_i,
	output logic [read_format_pkg::field_width-1:0] wr_min_intv
);

	logic [1:0] phase;
	logic accept;

	// beats past the batch or past the buffer depth are dropped
	assign accept = load_valid && !load_done && (read_count < batch_size)
		&& (read_count < read_geometry_pkg::max_reads);

	assign wr_en = accept;
	assign wr_sel = phase;
	assign wr_read_num = read_count[read_geometry_pkg::read_num_width-1:0];
	assign wr_forward_i = load_data.param.forward_i;
	assign wr_min_intv = load_data.param.min_intv;

	// keep only the base code of every lane
	always_comb begin
		for (int i = 0; i < read_geometry_pkg::bases_per_word; i++) begin
			wr_bases[i*read_geometry_pkg::base_width +: read_geometry_pkg::base_width] =
				load_data.lanes[i][read_geometry_pkg::base_width-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			phase <= read_format_pkg::phase_base_lo;
			read_count <= '0;
			load_done <= 1'b0;
		end else begin
			if (accept) begin
				case (phase)
					read_format_pkg::phase_base_lo: phase <= read_format_pkg::phase_base_hi;
					read_format_pkg::phase_base_hi: phase <= read_format_pkg::phase_param;
					default: begin
						phase <= read_format_pkg::phase_base_lo;
						read_count <= read_count + 1'b1;
					end
				endcase
			end
			// sticky until reset and never set for a zero batch
			if (read_count == batch_size && batch_size != '0)
				load_done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- read_store.sv
`default_nettype none
`timescale 1ns/1ns

module read_store (
	input wire clk,
	input wire wr_en,
	input wire [1:0] wr_sel,
	input wire [read_geometry_pkg::read_num_width-1:0] wr_read_num,
	input wire [read_geometry_pkg::packed_word_width-1:0] wr_bases,
	input wire [read_format_pkg::field_width-1:0] wr_forward_i,
	input wire [read_format_pkg::field_width-1:0] wr_min_intv,
	input wire [read_geometry_pkg::read_num_width-1:0] disp_read_num,
	output logic [read_format_pkg::field_width-1:0] disp_forward_i,
	output logic [read_format_pkg::field_width-1:0] disp_min_intv,
	input wire [read_geometry_pkg::read_num_width-1:0] query_read_num,
	output logic [read_geometry_pkg::packed_word_width-1:0] query_word_lo,
	output logic [read_geometry_pkg::packed_word_width-1:0] query_word_hi
);

	logic [read_geometry_pkg::packed_word_width-1:0] mem_lo [read_geometry_pkg::max_reads];
	logic [read_geometry_pkg::packed_word_width-1:0] mem_hi [read_geometry_pkg::max_reads];
	logic [read_format_pkg::field_width-1:0] mem_forward_i [read_geometry_pkg::max_reads];
	logic [read_format_pkg::field_width-1:0] mem_min_intv [read_geometry_pkg::max_reads];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			case (wr_sel)
				read_format_pkg::phase_base_lo: mem_lo[wr_read_num] <= wr_bases;
				read_format_pkg::phase_base_hi: mem_hi[wr_read_num] <= wr_bases;
				read_format_pkg::phase_param: begin
					mem_forward_i[wr_read_num] <= wr_forward_i;
					mem_min_intv[wr_read_num] <= wr_min_intv;
				end
				default: ;
			endcase
		end
	end

	// both read ports are asynchronous
	assign disp_forward_i = mem_forward_i[disp_read_num];
	assign disp_min_intv = mem_min_intv[disp_read_num];
	assign query_word_lo = mem_lo[query_read_num];
	assign query_word_hi = mem_hi[query_read_num];

endmodule

`default_nettype wire

//--- read_dispatch.sv
`default_nettype none
`timescale 1ns/1ns

module read_dispatch (
	input wire clk,
	input wire reset_n,
	input wire stall,
	input wire load_done,
	input wire [read_geometry_pkg::batch_width-1:0] read_count,
	input wire new_read,
	output logic new_read_valid,
	output logic [read_geometry_pkg::read_num_width-1:0] new_read_num,
	output logic [read_geometry_pkg::read_num_width-1:0] disp_read_num
);

	// one bit wider than a read number so it can reach read_count
	logic [read_geometry_pkg::batch_width-1:0] read_ptr;

	assign new_read_valid = load_done && (read_ptr < read_count);
	assign disp_read_num = read_ptr[read_geometry_pkg::read_num_width-1:0];
	assign new_read_num = new_read_valid ? disp_read_num : '1;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			read_ptr <= '0;
		end else if (new_read && new_read_valid && !stall) begin
			read_ptr <= read_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- base_select_pipe.sv
`default_nettype none
`timescale 1ns/1ns

module base_select_pipe (
	input wire clk,
	input wire reset_n,
	input wire stall,
	input wire query_valid,
	input wire [read_geometry_pkg::position_width-1:0] query_position,
	input wire [read_geometry_pkg::packed_word_width-1:0] query_word_lo,
	input wire [read_geometry_pkg::packed_word_width-1:0] query_word_hi,
	output logic [read_geometry_pkg::result_width-1:0] query_base,
	output logic result_valid
);

	// stage 1 holds both words as four groups of 32 bases
	logic [3:0][63:0] s1_words;
	logic [6:0] s1_pos;
	logic s1_valid;

	// stage 2 holds 32 bases as four groups of 8
	logic [3:0][15:0] s2_bases;
	logic [4:0] s2_pos;
	logic s2_valid;

	// stage 3 holds 8 bases
	logic [7:0][read_geometry_pkg::base_width-1:0] s3_bases;
	logic [2:0] s3_pos;
	logic s3_valid;

	// data registers
	always_ff @(posedge clk) begin
		if (!stall) begin
			s1_words <= {query_word_hi, query_word_lo};
			s1_pos <= query_position;
			s2_bases <= s1_words[s1_pos[6:5]];
			s2_pos <= s1_pos[4:0];
			s3_bases <= s2_bases[s2_pos[4:3]];
			s3_pos <= s2_pos[2:0];
		end
	end

	// valid bits and the output register
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			result_valid <= 1'b0;
			query_base <= '1;
		end else if (!stall) begin
			s1_valid <= query_valid;
			s2_valid <= s1_valid;
			s3_valid <= s2_valid;
			result_valid <= s3_valid;
			// zero-extend the 2-bit code to a full lane
			query_base <= {{(read_geometry_pkg::result_width - read_geometry_pkg::base_width){1'b0}},
				s3_bases[s3_pos]};
		end
	end

endmodule

`default_nettype wire

//--- read_buffer.sv
`default_nettype none
`timescale 1ns/1ns

module read_buffer (
	input wire clk,
	input wire reset_n,
	input wire stall,
	input wire load_valid,
	input wire read_format_pkg::beat_t load_data,
	input wire [read_geometry_pkg::batch_width-1:0] batch_size,
	output logic load_done,
	input wire new_read,
	output logic new_read_valid,
	output logic [read_geometry_pkg::read_num_width-1:0] new_read_num,
	output logic [read_format_pkg::field_width-1:0] new_forward_i,
	output logic [read_format_pkg::field_width-1:0] new_min_intv,
	input wire query_valid,
	input wire [read_geometry_pkg::read_num_width-1:0] query_read_num,
	input wire [read_geometry_pkg::position_width-1:0] query_position,
	output logic [read_geometry_pkg::result_width-1:0] query_base,
	output logic result_valid
);

	logic [read_geometry_pkg::batch_width-1:0] read_count;
	logic wr_en;
	logic [1:0] wr_sel;
	logic [read_geometry_pkg::read_num_width-1:0] wr_read_num;
	logic [read_geometry_pkg::packed_word_width-1:0] wr_bases;
	logic [read_format_pkg::field_width-1:0] wr_forward_i;
	logic [read_format_pkg::field_width-1:0] wr_min_intv;
	logic [read_geometry_pkg::read_num_width-1:0] disp_read_num;
	logic [read_geometry_pkg::packed_word_width-1:0] query_word_lo;
	logic [read_geometry_pkg::packed_word_width-1:0] query_word_hi;

	read_loader u_read_loader (
		.clk(clk), .reset_n(reset_n),
		.load_valid(load_valid), .load_data(load_data), .batch_size(batch_size),
		.load_done(load_done), .read_count(read_count),
		.wr_en(wr_en), .wr_sel(wr_sel), .wr_read_num(wr_read_num),
		.wr_bases(wr_bases), .wr_forward_i(wr_forward_i), .wr_min_intv(wr_min_intv)
	);

	// parameter fields go straight out to the extension pipeline
	read_store u_read_store (
		.clk(clk),
		.wr_en(wr_en), .wr_sel(wr_sel), .wr_read_num(wr_read_num),
		.wr_bases(wr_bases), .wr_forward_i(wr_forward_i), .wr_min_intv(wr_min_intv),
		.disp_read_num(disp_read_num),
		.disp_forward_i(new_forward_i), .disp_min_intv(new_min_intv),
		.query_read_num(query_read_num),
		.query_word_lo(query_word_lo), .query_word_hi(query_word_hi)
	);

	read_dispatch u_read_dispatch (
		.clk(clk), .reset_n(reset_n), .stall(stall),
		.load_done(load_done), .read_count(read_count), .new_read(new_read),
		.new_read_valid(new_read_valid), .new_read_num(new_read_num),
		.disp_read_num(disp_read_num)
	);

	base_select_pipe u_base_select_pipe (
		.clk(clk), .reset_n(reset_n), .stall(stall),
		.query_valid(query_valid), .query_position(query_position),
		.query_word_lo(query_word_lo), .query_word_hi(query_word_hi),
		.query_base(query_base), .result_valid(result_valid)
	);

endmodule

`default_nettype wire

//--- read_buffer_checker.sv
`default_nettype none
`timescale 1ns/1ns

module read_buffer_checker (
	input wire clk,
	input wire reset_n,
	input wire load_done,
	input wire new_read_valid,
	input wire [read_geometry_pkg::read_num_width-1:0] new_read_num,
	input wire result_valid,
	input wire wr_en,
	input wire [1:0] wr_sel
);

	int failures;

	// done is sticky once set
	load_done_sticky: assert property (@(posedge clk)
		(reset_n && $past(reset_n) && $past(load_done)) |-> load_done)
		else begin
			$error("load_done fell without a reset");
			failures++;
		end

	idle_read_num: assert property (@(posedge clk)
		disable iff (!reset_n) !new_read_valid |-> new_read_num == '1)
		else begin
			$error("new_read_num not all ones while new_read_valid is low");
			failures++;
		end

	result_cleared: assert property (@(posedge clk) !reset_n |=> !result_valid)
		else begin
			$error("result_valid high in the cycle after reset");
			failures++;
		end

	// done rises only after the last parameter beat of the batch was written
	load_done_after_param: assert property (@(posedge clk)
		disable iff (!reset_n) $rose(load_done) |->
		$past(wr_en && wr_sel == read_format_pkg::phase_param, 2))
		else begin
			$error("load_done rose without a parameter write two cycles earlier");
			failures++;
		end

endmodule

bind read_buffer read_buffer_checker u_read_buffer_checker (
	.clk(clk), .reset_n(reset_n), .load_done(load_done),
	.new_read_valid(new_read_valid), .new_read_num(new_read_num),
	.result_valid(result_valid), .wr_en(wr_en), .wr_sel(wr_sel)
);

`default_nettype wire

//--- read_buffer_monitor.sv
`default_nettype none
`timescale 1ns/1ns

module read_buffer_monitor (
	input wire clk,
	input wire reset_n,
	input wire stall,
	input wire load_valid,
	input wire read_format_pkg::beat_t load_data,
	input wire [read_geometry_pkg::batch_width-1:0] batch_size,
	input wire load_done,
	input wire new_read,
	input wire new_read_valid,
	input wire [read_geometry_pkg::read_num_width-1:0] new_read_num,
	input wire [read_format_pkg::field_width-1:0] new_forward_i,
	input wire [read_format_pkg::field_width-1:0] new_min_intv,
	input wire query_valid,
	input wire [read_geometry_pkg::read_num_width-1:0] query_read_num,
	input wire [read_geometry_pkg::position_width-1:0] query_position,
	input wire [read_geometry_pkg::result_width-1:0] query_base,
	input wire result_valid,
	output int error_count,
	output int results_seen
);

	// lanes kept exactly as they arrived with positions 64..127 from the second beat
	logic [7:0] m_lanes [read_geometry_pkg::max_reads][128];
	logic [6:0] m_fwd [read_geometry_pkg::max_reads];
	logic [6:0] m_min [read_geometry_pkg::max_reads];
	logic [1:0] m_beat;
	logic [4:0] m_count;
	logic [4:0] m_ptr;
	logic m_done;
	logic exp_nrv;
	// expected contents of the four query stages
	logic [3:0] exp_valid;
	logic [7:0] exp_base [4];
	bit in_reset;
	bit active;

	assign exp_nrv = m_done && (m_ptr < m_count);

	task automatic flag_mismatch(input string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		error_count++;
	endtask

	always @(posedge clk) begin
		in_reset <= !reset_n;
		active <= reset_n;
		if (!reset_n) begin
			m_beat <= 2'd0;
			m_count <= '0;
			m_ptr <= '0;
			m_done <= 1'b0;
			exp_valid <= '0;
		end else begin
			if (load_valid && !m_done && m_count < batch_size) begin
				for (int i = 0; i < 64; i++) begin
					if (m_beat == 2'd0)
						m_lanes[m_count[3:0]][i] <= load_data[i*8 +: 8];
					if (m_beat == 2'd1)
						m_lanes[m_count[3:0]][64+i] <= load_data[i*8 +: 8];
				end
				if (m_beat == 2'd2) begin
					m_fwd[m_count[3:0]] <= load_data[6:0];
					m_min[m_count[3:0]] <= load_data[70:64];
					m_count <= m_count + 5'd1;
				end
				m_beat <= (m_beat == 2'd2) ? 2'd0 : m_beat + 2'd1;
			end
			if (m_count == batch_size && batch_size != '0)
				m_done <= 1'b1;
			if (new_read && exp_nrv && !stall)
				m_ptr <= m_ptr + 5'd1;
			if (!stall) begin
				exp_valid <= {exp_valid[2:0], query_valid};
				exp_base[0] <= {6'b0, m_lanes[query_read_num][query_position][1:0]};
				exp_base[1] <= exp_base[0];
				exp_base[2] <= exp_base[1];
				exp_base[3] <= exp_base[2];
				if (result_valid)
					results_seen++;
			end
		end
	end

	always @(negedge clk) begin
		if (in_reset) begin
			if (query_base !== 8'hff)
				flag_mismatch($sformatf("query_base %h in reset, expected ff", query_base));
			if (load_done !== 1'b0 || new_read_valid !== 1'b0 || result_valid !== 1'b0)
				flag_mismatch("load_done, new_read_valid or result_valid high in reset");
		end else if (active) begin
			if (load_done !== m_done)
				flag_mismatch($sformatf("load_done %b, expected %b", load_done, m_done));
			if (new_read_valid !== exp_nrv)
				flag_mismatch($sformatf("new_read_valid %b, expected %b", new_read_valid, exp_nrv));
			if (exp_nrv && (new_read_num !== m_ptr[3:0] || new_forward_i !== m_fwd[m_ptr[3:0]]
				|| new_min_intv !== m_min[m_ptr[3:0]]))
				flag_mismatch($sformatf("read %0d handed out as %0d, fwd %0d, min %0d", m_ptr,
					new_read_num, new_forward_i, new_min_intv));
			if (!exp_nrv && new_read_num !== '1)
				flag_mismatch($sformatf("new_read_num %h while no read is offered", new_read_num));
			if (result_valid !== exp_valid[3])
				flag_mismatch($sformatf("result_valid %b, expected %b", result_valid, exp_valid[3]));
			if (exp_valid[3] && query_base !== exp_base[3])
				flag_mismatch($sformatf("query_base %h, expected %h", query_base, exp_base[3]));
		end
	end

endmodule

`default_nettype wire

//--- tb_read_buffer.sv
`default_nettype none
`timescale 1ns/1ns

module tb_read_buffer;

	localparam int num_reads = 5;
	localparam int num_queries = 10;
	localparam int wait_load = 0;
	localparam int wait_dispatch = 1;
	localparam int wait_results = 2;

	logic clk;
	logic reset_n;
	logic stall;
	logic load_valid;
	read_format_pkg::beat_t load_data;
	logic [read_geometry_pkg::batch_width-1:0] batch_size;
	logic load_done;
	logic new_read;
	logic new_read_valid;
	logic [read_geometry_pkg::read_num_width-1:0] new_read_num;
	logic [read_format_pkg::field_width-1:0] new_forward_i;
	logic [read_format_pkg::field_width-1:0] new_min_intv;
	logic query_valid;
	logic [read_geometry_pkg::read_num_width-1:0] query_read_num;
	logic [read_geometry_pkg::position_width-1:0] query_position;
	logic [read_geometry_pkg::result_width-1:0] query_base;
	logic result_valid;
	int error_count;
	int results_seen;
	int timeouts;
	int total_errors;
	integer seed;

	// per-read parameters, then queries as read, position and a stall flag
	logic [6:0] fwd_table [num_reads] = '{7'd3, 7'd17, 7'd64, 7'd100, 7'd127};
	logic [6:0] min_table [num_reads] = '{7'd1, 7'd9, 7'd33, 7'd2, 7'd120};
	logic [3:0] qread_table [num_queries] = '{0, 1, 2, 3, 4, 0, 4, 2, 1, 3};
	logic [6:0] qpos_table [num_queries] = '{0, 63, 64, 127, 5, 70, 33, 100, 17, 90};
	bit qstall_table [num_queries] = '{0, 0, 0, 0, 1, 0, 0, 0, 1, 0};

	read_buffer u_read_buffer (.*);

	read_buffer_monitor u_read_buffer_monitor (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [511:0] random_beat();
		logic [511:0] beat;
		for (int k = 0; k < 16; k++)
			beat[k*32 +: 32] = $random(seed);
		return beat;
	endfunction

	function automatic bit condition_met(input int what);
		case (what)
			wait_load: return load_done;
			wait_dispatch: return new_read_valid;
			default: return results_seen == num_queries;
		endcase
	endfunction

	task automatic wait_until(input int what, input string what_name);
		int cycles;
		cycles = 0;
		while (!condition_met(what) && cycles < 100) begin
			@(negedge clk);
			cycles++;
		end
		if (!condition_met(what)) begin
			$display("timeout: gave up waiting for %s", what_name);
			timeouts++;
		end
	endtask

	task automatic send_beat(input logic [511:0] data);
		load_valid = 1'b1;
		load_data = data;
		@(negedge clk);
	endtask

	initial begin
		logic [511:0] param_beat;
		seed = 89;
		reset_n = 1'b0;
		stall = 1'b0;
		load_valid = 1'b0;
		load_data = '0;
		batch_size = 5'd5;
		new_read = 1'b0;
		query_valid = 1'b0;
		query_read_num = '0;
		query_position = '0;
		timeouts = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		// every lane is fully random and only its low two bits are a base
		for (int r = 0; r < num_reads; r++) begin
			send_beat(random_beat());
			send_beat(random_beat());
			param_beat = random_beat();
			param_beat[6:0] = fwd_table[r];
			param_beat[70:64] = min_table[r];
			send_beat(param_beat);
		end
		load_valid = 1'b0;
		wait_until(wait_load, "load_done after the batch");
		// beats past the batch are dropped
		repeat (3) send_beat(random_beat());
		load_valid = 1'b0;
		repeat (2) @(negedge clk);
		for (int r = 0; r < num_reads; r++) begin
			wait_until(wait_dispatch, "new_read_valid");
			new_read = 1'b1;
			stall = (r == 2);
			@(negedge clk);
			if (r == 2) begin
				stall = 1'b0;
				@(negedge clk);
			end
			new_read = 1'b0;
			@(negedge clk);
		end
		// back to back queries where a flagged one stalls for a cycle
		for (int q = 0; q < num_queries; q++) begin
			query_valid = 1'b1;
			query_read_num = qread_table[q];
			query_position = qpos_table[q];
			stall = qstall_table[q];
			@(negedge clk);
			if (qstall_table[q]) begin
				stall = 1'b0;
				@(negedge clk);
			end
		end
		query_valid = 1'b0;
		wait_until(wait_results, "all query results");
		repeat (2) @(negedge clk);
		total_errors = error_count + u_read_buffer.u_read_buffer_checker.failures;
		$display("errors: %0d, timeouts: %0d", total_errors, timeouts);
		if (total_errors == 0 && timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- read_buffer.f
read_geometry_pkg.sv
read_format_pkg.sv
read_loader.sv
read_store.sv
read_dispatch.sv
base_select_pipe.sv
read_buffer.sv
read_buffer_checker.sv
read_buffer_monitor.sv
tb_read_buffer.sv

//--- Makefile
TOP = tb_read_buffer

all: run

build:
	verilator --binary --timing --assert -f read_buffer.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -f read_buffer.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
